/* source/cache_pkg.sv */
// cache package with the geometry, address decode and the line, request and response types
package cache_pkg;

  localparam int num_sets    = 16;
  localparam int num_ways    = 4;
  localparam int set_bits    = 4;
  localparam int offset_bits = 3;
  localparam int tag_bits    = 25;
  localparam int way_bits    = 2;
  localparam int vb_entries  = 4;
  localparam int vb_ptr_bits = 2;

  // tag | set index | byte offset
  typedef struct packed {
    logic [tag_bits-1:0]    tag;
    logic [set_bits-1:0]    idx;
    logic [offset_bits-1:0] offset;
  } addr_fields_t;

  typedef union packed {
    logic [31:0]  word;
    addr_fields_t fields;
  } cache_addr_u;

  typedef struct packed {
    logic [63:0]         data;
    logic [tag_bits-1:0] tag;
    logic                valid;
    logic                dirty;
  } cache_line_t;

  typedef struct packed {
    logic        en;
    cache_addr_u addr;
  } rd_req_t;

  typedef struct packed {
    logic        en;
    cache_addr_u addr;
    logic [63:0] data;
    logic        dirty;
  } wr_req_t;

  typedef struct packed {
    logic        hit;
    logic        miss;
    logic [63:0] data;
  } rd_resp_t;

  // line displaced from the main array
  typedef struct packed {
    logic                valid;
    logic [set_bits-1:0] idx;
    cache_line_t         line;
  } evict_t;

  // dirty line leaving the core
  typedef struct packed {
    logic        valid;
    logic [28:0] line_addr;
    logic [63:0] data;
  } wb_t;

endpackage

/* source/tag_cam.sv */
// tag cam that matches one tag against every way of a set and encodes the hit way
module tag_cam (
  input  logic [cache_pkg::tag_bits-1:0]                   tag,
  input  cache_pkg::cache_line_t [cache_pkg::num_ways-1:0] lines,
  output logic                                             hit,
  output logic [cache_pkg::way_bits-1:0]                   way
);

  import cache_pkg::*;

  logic [num_ways-1:0] match;

  // only valid ways take part in the compare
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      match[w] = lines[w].valid && (lines[w].tag == tag);
    end
  end

  // lowest matching way wins
  always_comb begin
    hit = |match;
    way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (match[w]) begin
        way = way_bits'(w);
      end
    end
  end

endmodule

/* source/plru_tree.sv */
// per-set tree pseudo-lru bits with hit touch and miss victim selection
module plru_tree (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          rd_touch,
  input  logic [cache_pkg::set_bits-1:0] rd_idx,
  input  logic [cache_pkg::way_bits-1:0] rd_way,
  input  logic                          wr_en,
  input  logic                          wr_hit,
  input  logic [cache_pkg::set_bits-1:0] wr_idx,
  input  logic [cache_pkg::way_bits-1:0] wr_way,
  output logic [cache_pkg::way_bits-1:0] victim_way
);

  import cache_pkg::*;

  // bit 0 root, bit 1 left child, bit 2 right child; a set bit points right
  logic [num_sets-1:0][num_ways-2:0] tree_q;
  logic [num_sets-1:0][num_ways-2:0] tree_d;
  logic [num_ways-2:0]               wr_bits;

  // point root and child away from way w
  function automatic logic [num_ways-2:0] touch(input logic [num_ways-2:0] bits,
                                                input logic [way_bits-1:0] w);
    logic [num_ways-2:0] t;
    t = bits;
    t[0] = ~w[1];
    if (w[1]) begin
      t[2] = ~w[0];
    end else begin
      t[1] = ~w[0];
    end
    return t;
  endfunction

  // invert the bits on the path the walk followed
  function automatic logic [num_ways-2:0] flip_path(input logic [num_ways-2:0] bits);
    logic [num_ways-2:0] t;
    t = bits;
    t[0] = ~bits[0];
    if (bits[0]) begin
      t[2] = ~bits[2];
    end else begin
      t[1] = ~bits[1];
    end
    return t;
  endfunction

  assign wr_bits = tree_q[wr_idx];

  // walk from the root following the current bits
  assign victim_way = {wr_bits[0], wr_bits[0] ? wr_bits[2] : wr_bits[1]};

  // write update first, read touch on top of it
  always_comb begin
    tree_d = tree_q;
    if (wr_en) begin
      if (wr_hit) begin
        tree_d[wr_idx] = touch(wr_bits, wr_way);
      end else begin
        tree_d[wr_idx] = flip_path(wr_bits);
      end
    end
    if (rd_touch) begin
      tree_d[rd_idx] = touch(tree_d[rd_idx], rd_way);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tree_q <= '0;
    end else begin
      tree_q <= tree_d;
    end
  end

endmodule

/* source/cachemem.sv */
// set-associative cache memory with lookup, forwarding, fill and eviction
module cachemem (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           rd_en,
  input  logic [cache_pkg::set_bits-1:0] rd_idx,
  input  logic [cache_pkg::tag_bits-1:0] rd_tag,
  input  logic                           wr_en,
  input  logic [cache_pkg::set_bits-1:0] wr_idx,
  input  logic [cache_pkg::tag_bits-1:0] wr_tag,
  input  logic [63:0]                    wr_data,
  input  logic                           wr_dirty,
  output logic                           rd_hit,
  output logic [63:0]                    rd_data,
  output cache_pkg::evict_t              evict
);

  import cache_pkg::*;

  cache_line_t [num_ways-1:0] sets_q [num_sets];

  cache_line_t [num_ways-1:0] rd_set;
  cache_line_t [num_ways-1:0] wr_set;
  cache_line_t                victim_line;

  logic                rd_cam_hit;
  logic [way_bits-1:0] rd_cam_way;
  logic                wr_cam_hit;
  logic [way_bits-1:0] wr_cam_way;
  logic [way_bits-1:0] victim_way;
  logic [way_bits-1:0] wr_way;
  logic                fwd;

  assign rd_set = sets_q[rd_idx];
  assign wr_set = sets_q[wr_idx];

  tag_cam rd_cam_i (
    .tag   (rd_tag),
    .lines (rd_set),
    .hit   (rd_cam_hit),
    .way   (rd_cam_way)
  );

  tag_cam wr_cam_i (
    .tag   (wr_tag),
    .lines (wr_set),
    .hit   (wr_cam_hit),
    .way   (wr_cam_way)
  );

  // touches only on a real array hit, not on a forward
  plru_tree plru_i (
    .clock      (clock),
    .reset      (reset),
    .rd_touch   (rd_en && rd_cam_hit),
    .rd_idx     (rd_idx),
    .rd_way     (rd_cam_way),
    .wr_en      (wr_en),
    .wr_hit     (wr_cam_hit),
    .wr_idx     (wr_idx),
    .wr_way     (wr_cam_way),
    .victim_way (victim_way)
  );

  // same-cycle write to the same line
  assign fwd = rd_en && wr_en && (rd_idx == wr_idx) && (rd_tag == wr_tag);

  always_comb begin
    if (fwd) begin
      rd_hit  = 1'b1;
      rd_data = wr_data;
    end else begin
      rd_hit  = rd_en && rd_cam_hit;
      rd_data = rd_set[rd_cam_way].data;
    end
  end

  // hit way is overwritten, else the plru victim is filled
  assign wr_way      = wr_cam_hit ? wr_cam_way : victim_way;
  assign victim_line = wr_set[victim_way];

  always_comb begin
    evict.valid = wr_en && !wr_cam_hit && victim_line.valid;
    evict.idx   = wr_idx;
    evict.line  = victim_line;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        sets_q[s] <= '0;
      end
    end else if (wr_en) begin
      sets_q[wr_idx][wr_way] <= '{data: wr_data, tag: wr_tag, valid: 1'b1, dirty: wr_dirty};
    end
  end

endmodule

/* source/victim_buffer.sv */
// small fully associative victim buffer of evicted lines with dirty write-back
module victim_buffer (
  input  logic                 clock,
  input  logic                 reset,
  input  cache_pkg::evict_t    evict,
  input  logic [28:0]          rd_line_addr,
  input  logic                 wr_en,
  input  logic [28:0]          wr_line_addr,
  output logic                 rd_hit,
  output logic [63:0]          rd_data,
  output cache_pkg::wb_t       wb
);

  import cache_pkg::*;

  logic [vb_entries-1:0] ent_valid_q;
  logic [vb_entries-1:0] ent_valid_d;
  logic [vb_entries-1:0] ent_dirty;
  logic [28:0]           ent_addr [vb_entries];
  logic [63:0]           ent_data [vb_entries];
  logic [vb_ptr_bits-1:0] head_q;

  logic [28:0]           evict_addr;
  logic [vb_entries-1:0] rd_match;
  logic [vb_entries-1:0] wr_match;

  assign evict_addr = {evict.line.tag, evict.idx};

  always_comb begin
    for (int i = 0; i < vb_entries; i++) begin
      rd_match[i] = ent_valid_q[i] && (ent_addr[i] == rd_line_addr);
      wr_match[i] = wr_en && ent_valid_q[i] && (ent_addr[i] == wr_line_addr);
    end
  end

  // lowest matching entry
  always_comb begin
    rd_hit  = 1'b0;
    rd_data = '0;
    for (int i = vb_entries - 1; i >= 0; i--) begin
      if (rd_match[i]) begin
        rd_hit  = 1'b1;
        rd_data = ent_data[i];
      end
    end
  end

  // head slot falls out when overwritten, unless a write made it stale
  assign wb.valid     = evict.valid && ent_valid_q[head_q] && ent_dirty[head_q] &&
                        !wr_match[head_q];
  assign wb.line_addr = ent_addr[head_q];
  assign wb.data      = ent_data[head_q];

  always_comb begin
    ent_valid_d = ent_valid_q & ~wr_match;
    if (evict.valid) begin
      ent_valid_d[head_q] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ent_valid_q <= '0;
      head_q      <= '0;
    end else begin
      ent_valid_q <= ent_valid_d;
      if (evict.valid) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (evict.valid) begin
      ent_dirty[head_q] <= evict.line.dirty;
      ent_addr[head_q]  <= evict_addr;
      ent_data[head_q]  <= evict.line.data;
    end
  end

endmodule

/* source/dcache_top.sv */
// data cache top level that decodes addresses and merges the array and victim buffer reads
module dcache_top (
  input  logic                clock,
  input  logic                reset,
  input  cache_pkg::rd_req_t  rd_req,
  input  cache_pkg::wr_req_t  wr_req,
  output cache_pkg::rd_resp_t rd_resp,
  output cache_pkg::wb_t      wb
);

  import cache_pkg::*;

  logic        mem_rd_hit;
  logic [63:0] mem_rd_data;
  evict_t      evict;
  logic        vb_rd_hit;
  logic [63:0] vb_rd_data;
  logic        vb_hit;
  logic [28:0] rd_line_addr;
  logic [28:0] wr_line_addr;

  // line address is the word without the byte offset
  assign rd_line_addr = rd_req.addr.word[31:offset_bits];
  assign wr_line_addr = wr_req.addr.word[31:offset_bits];

  cachemem cachemem_i (
    .clock    (clock),
    .reset    (reset),
    .rd_en    (rd_req.en),
    .rd_idx   (rd_req.addr.fields.idx),
    .rd_tag   (rd_req.addr.fields.tag),
    .wr_en    (wr_req.en),
    .wr_idx   (wr_req.addr.fields.idx),
    .wr_tag   (wr_req.addr.fields.tag),
    .wr_data  (wr_req.data),
    .wr_dirty (wr_req.dirty),
    .rd_hit   (mem_rd_hit),
    .rd_data  (mem_rd_data),
    .evict    (evict)
  );

  victim_buffer victim_buffer_i (
    .clock        (clock),
    .reset        (reset),
    .evict        (evict),
    .rd_line_addr (rd_line_addr),
    .wr_en        (wr_req.en),
    .wr_line_addr (wr_line_addr),
    .rd_hit       (vb_rd_hit),
    .rd_data      (vb_rd_data),
    .wb           (wb)
  );

  assign vb_hit = rd_req.en && vb_rd_hit;

  // main array first and the buffer as fallback
  assign rd_resp.hit  = mem_rd_hit || vb_hit;
  assign rd_resp.miss = rd_req.en && !(mem_rd_hit || vb_hit);
  assign rd_resp.data = mem_rd_hit ? mem_rd_data : vb_rd_data;

endmodule

/* verif/dcache_props.sv */
// dcache port properties for read response and write-back sanity
module dcache_props (
  input logic                clock,
  input logic                reset,
  input cache_pkg::rd_req_t  rd_req,
  input cache_pkg::wr_req_t  wr_req,
  input cache_pkg::rd_resp_t rd_resp,
  input cache_pkg::wb_t      wb
);

  timeunit 1ns;
  timeprecision 1ps;

  hit_miss_exclusive: assert property (@(posedge clock) !(rd_resp.hit && rd_resp.miss))
    else $error("rd_resp.hit and rd_resp.miss are high together");

  // no response without a read strobe
  resp_needs_read: assert property (@(posedge clock)
    !rd_req.en |-> !rd_resp.hit && !rd_resp.miss)
    else $error("read response without rd_req.en");

  wb_needs_write: assert property (@(posedge clock) wb.valid |-> wr_req.en)
    else $error("wb.valid without wr_req.en");

  quiet_in_reset: assert property (@(posedge clock)
    reset |-> !rd_resp.hit && !rd_resp.miss && !wb.valid)
    else $error("outputs active during reset");

endmodule

bind dcache_top dcache_props dcache_props_i (
  .clock   (clock),
  .reset   (reset),
  .rd_req  (rd_req),
  .wr_req  (wr_req),
  .rd_resp (rd_resp),
  .wb      (wb)
);

/* verif/dcache_tb.sv */
// data cache testbench with directed and seeded random traffic against a behavioral model
module dcache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  logic     clock;
  logic     reset;
  rd_req_t  rd_req;
  wr_req_t  wr_req;
  rd_resp_t rd_resp;
  wb_t      wb;
  integer   seed;
  logic     finished;

  // reference model state
  cache_line_t m_lines [num_sets][num_ways];
  logic [2:0]  m_tree [num_sets];
  logic        vb_valid [vb_entries];
  logic        vb_dirty [vb_entries];
  logic [28:0] vb_addr [vb_entries];
  logic [63:0] vb_data [vb_entries];
  int          vb_head;

  dcache_top dcache_top_i (
    .clock   (clock),
    .reset   (reset),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_resp (rd_resp),
    .wb      (wb)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      finished = 1'b1;
      $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "%s mismatch", what);
    end
  endtask

  // lowest valid way holding the tag or -1
  function automatic int find_way(input int s, input logic [tag_bits-1:0] tag);
    int r;
    r = -1;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (m_lines[s][w].valid && m_lines[s][w].tag == tag) begin
        r = w;
      end
    end
    return r;
  endfunction

  function automatic int find_vb(input logic [28:0] line_addr);
    int r;
    r = -1;
    for (int i = vb_entries - 1; i >= 0; i--) begin
      if (vb_valid[i] && vb_addr[i] == line_addr) begin
        r = i;
      end
    end
    return r;
  endfunction

  // root in bit 0 picks the half and bit 1 or bit 2 picks the way
  function automatic int plru_way(input logic [2:0] t);
    if (!t[0]) begin
      return t[1] ? 1 : 0;
    end
    return t[2] ? 3 : 2;
  endfunction

  function automatic logic [2:0] plru_touch(input logic [2:0] t, input int w);
    logic [2:0] n;
    n = t;
    n[0] = (w < 2);
    if (w < 2) begin
      n[1] = (w == 0);
    end else begin
      n[2] = (w == 2);
    end
    return n;
  endfunction

  function automatic logic [2:0] plru_flip(input logic [2:0] t);
    logic [2:0] n;
    n = t;
    n[0] = ~t[0];
    if (t[0]) begin
      n[2] = ~t[2];
    end else begin
      n[1] = ~t[1];
    end
    return n;
  endfunction

  function automatic logic [31:0] mk_addr(input logic [tag_bits-1:0] tag,
                                          input logic [set_bits-1:0] idx);
    cache_addr_u a;
    a.fields.tag    = tag;
    a.fields.idx    = idx;
    a.fields.offset = '0;
    return a.word;
  endfunction

  // six tags over two sets keeps hits and evictions frequent
  function automatic logic [31:0] rand_addr();
    cache_addr_u a;
    a.fields.tag    = 25'h1a0 + 25'($unsigned($random(seed)) % 6);
    a.fields.idx    = (($random(seed) & 1) == 1) ? 4'd9 : 4'd2;
    a.fields.offset = 3'($random(seed));
    return a.word;
  endfunction

  task automatic apply_cycle(input logic rd_en, input logic [31:0] rd_addr, input logic wr_en,
                             input logic [31:0] wr_addr, input logic [63:0] data,
                             input logic dirty);
    cache_addr_u ra;
    cache_addr_u wa;
    logic [28:0] rline;
    logic [28:0] wline;
    int          ri;
    int          wi;
    int          rway;
    int          wway;
    int          vbi;
    int          vict;
    int          h;
    logic        exp_hit;
    logic [63:0] exp_data;
    logic        evicting;
    logic        exp_wb;
    ra.word = rd_addr;
    wa.word = wr_addr;
    rline   = ra.word[31:offset_bits];
    wline   = wa.word[31:offset_bits];
    ri      = ra.fields.idx;
    wi      = wa.fields.idx;
    @(posedge clock);
    #1;
    rd_req.en    = rd_en;
    rd_req.addr  = ra;
    wr_req.en    = wr_en;
    wr_req.addr  = wa;
    wr_req.data  = data;
    wr_req.dirty = dirty;
    #49;
    rway     = find_way(ri, ra.fields.tag);
    wway     = find_way(wi, wa.fields.tag);
    vbi      = find_vb(rline);
    exp_hit  = 1'b0;
    exp_data = '0;
    if (rd_en && wr_en && rline == wline) begin
      exp_hit  = 1'b1;
      exp_data = data;
    end else if (rd_en && rway >= 0) begin
      exp_hit  = 1'b1;
      exp_data = m_lines[ri][rway].data;
    end else if (rd_en && vbi >= 0) begin
      exp_hit  = 1'b1;
      exp_data = vb_data[vbi];
    end
    check("rd_resp.hit", 64'(rd_resp.hit), 64'(exp_hit));
    check("rd_resp.miss", 64'(rd_resp.miss), 64'(rd_en && !exp_hit));
    if (exp_hit) begin
      check("rd_resp.data", rd_resp.data, exp_data);
    end
    vict     = plru_way(m_tree[wi]);
    evicting = wr_en && wway < 0 && m_lines[wi][vict].valid;
    h        = vb_head;
    exp_wb   = evicting && vb_valid[h] && vb_dirty[h] && vb_addr[h] != wline;
    check("wb.valid", 64'(wb.valid), 64'(exp_wb));
    if (exp_wb) begin
      check("wb.line_addr", 64'(wb.line_addr), 64'(vb_addr[h]));
      check("wb.data", wb.data, vb_data[h]);
    end
    // model state after the coming edge
    if (wr_en) begin
      m_tree[wi] = (wway >= 0) ? plru_touch(m_tree[wi], wway) : plru_flip(m_tree[wi]);
    end
    if (rd_en && rway >= 0) begin
      m_tree[ri] = plru_touch(m_tree[ri], rway);
    end
    for (int i = 0; i < vb_entries; i++) begin
      if (wr_en && vb_valid[i] && vb_addr[i] == wline) begin
        vb_valid[i] = 1'b0;
      end
    end
    if (evicting) begin
      vb_valid[h] = 1'b1;
      vb_dirty[h] = m_lines[wi][vict].dirty;
      vb_addr[h]  = {m_lines[wi][vict].tag, wa.fields.idx};
      vb_data[h]  = m_lines[wi][vict].data;
      vb_head     = (h + 1) % vb_entries;
    end
    if (wr_en) begin
      m_lines[wi][(wway >= 0) ? wway : vict] =
        '{data: data, tag: wa.fields.tag, valid: 1'b1, dirty: dirty};
    end
  endtask

  initial begin
    seed     = 32'hc86aae49;
    finished = 1'b0;
    reset    = 1'b1;
    rd_req   = '0;
    wr_req   = '0;
    vb_head  = 0;
    for (int s = 0; s < num_sets; s++) begin
      m_tree[s] = '0;
      for (int w = 0; w < num_ways; w++) begin
        m_lines[s][w] = '0;
      end
    end
    for (int i = 0; i < vb_entries; i++) begin
      vb_valid[i] = 1'b0;
      vb_dirty[i] = 1'b0;
      vb_addr[i]  = '0;
      vb_data[i]  = '0;
    end
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;
    for (int n = 0; n < 10 && (rd_resp.hit || rd_resp.miss || wb.valid); n++) begin
      @(posedge clock);
    end
    if (rd_resp.hit || rd_resp.miss || wb.valid) begin
      finished = 1'b1;
      $display("outputs did not go quiet after reset");
      $display("TEST RESULT: FAIL");
      $fatal(1, "reset wait timed out");
    end
    // nine tags into set 5 while the first tag is read every cycle
    for (int k = 0; k < 9; k++) begin
      apply_cycle(1'b1, mk_addr(25'h0a5, 4'd5), 1'b1, mk_addr(25'h0a5 + 25'(k), 4'd5),
                  {$random(seed), $random(seed)}, k % 3 != 1);
    end
    for (int k = 0; k < 9; k++) begin
      apply_cycle(1'b1, mk_addr(25'h0a5 + 25'(k), 4'd5), 1'b0, '0, '0, 1'b0);
    end
    // forwarded write, then read back
    for (int k = 0; k < 9; k++) begin
      apply_cycle(1'b1, mk_addr(25'h0a5 + 25'(k), 4'd5), 1'b1, mk_addr(25'h0a5 + 25'(k), 4'd5),
                  {$random(seed), $random(seed)}, 1'b1);
      apply_cycle(1'b1, mk_addr(25'h0a5 + 25'(k), 4'd5), 1'b0, '0, '0, 1'b0);
    end
    for (int n = 0; n < 4000; n++) begin
      apply_cycle($random(seed) % 4 != 0, rand_addr(), ($random(seed) & 1) == 1, rand_addr(),
                  {$random(seed), $random(seed)}, $random(seed) % 2 != 0);
    end
    finished = 1'b1;
    $display("TEST RESULT: PASS");
    $finish;
  end

  // reached when an assertion stops the run early
  final begin
    if (!finished) begin
      $display("simulation stopped before the test completed");
      $display("TEST RESULT: FAIL");
    end
  end

endmodule

/* project.f */
source/cache_pkg.sv
source/tag_cam.sv
source/plru_tree.sv
source/cachemem.sv
source/victim_buffer.sv
source/dcache_top.sv
verif/dcache_props.sv
verif/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the dcache testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module dcache_tb -o dcache_sim || exit 1
result=$(./obj_dir/dcache_sim 2>&1)
echo "$result"
echo "$result" | grep -qx "TEST RESULT: PASS" && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
